// File: filelist.f
+incdir+src
src/zxuno_pkg.sv
src/zxuno_regaddr.sv
src/coreid_reader.sv
src/config_regs.sv
src/zxuno_io.sv
test/tb_zxuno_io.sv

// File: Makefile
# Verilator simulation of the ZX-Uno I/O register block

VERILATOR  ?= verilator
TOP        ?= tb_zxuno_io
RTL_TOP    ?= zxuno_io
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Result: FAILED
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result, a crash counts as failure too
run: build
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_zxuno_io.sv
`timescale 1ns/100ps
`default_nettype none

`include "zxuno_config.svh"

module tb_zxuno_io;

  localparam real         CLK_HALF_NS    = 2.0;
  localparam real         DRIVE_DELAY    = 0.5;
  localparam int          RESET_CYCLES   = 5;
  localparam int          MAX_BUS_CYCLES = 200;
  localparam int          CLOCKS_PER_BUS = 4;
  localparam real         TIMEOUT_NS     =
    (RESET_CYCLES + MAX_BUS_CYCLES * CLOCKS_PER_BUS) * 2.0 * CLK_HALF_NS;
  localparam int unsigned RAND_SEED      = 32'h1a44_00cd;
  // Register number with no block behind it
  localparam logic [7:0]  UNUSED_REG     = 8'h55;

  logic                sysclk;
  logic                rst_n;
  zxuno_pkg::cpu_bus_t cpu;
  logic [7:0]          cpu_din;
  zxuno_pkg::devopts_t devopts;

  string       test_name;
  string       id_text;
  logic [7:0]  value;

  zxuno_io zxuno_io_inst (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .cpu     (cpu),
    .cpu_din (cpu_din),
    .devopts (devopts)
  );

  initial sysclk = 1'b0;
  always #(CLK_HALF_NS) sysclk = ~sysclk;

  // ----------------------------------------
  // Failure reporting
  // ----------------------------------------
  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic report_mismatch(string name, logic [7:0] expected, logic [7:0] actual);
    $display("CHECK FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    abort_run();
  endtask

  // Interrupt acknowledge always puts 0xFF on the bus
  assert property (@(posedge sysclk) disable iff (!rst_n)
    (!cpu.iorq_n && !cpu.m1_n) |-> (cpu_din == 8'hFF))
    else report_mismatch("intack", 8'hFF, cpu_din);

  // ----------------------------------------
  // Z80 bus cycles
  // ----------------------------------------
  task automatic release_strobes();
    cpu.iorq_n = 1'b1;
    cpu.m1_n   = 1'b1;
    cpu.rd_n   = 1'b1;
    cpu.wr_n   = 1'b1;
  endtask

  // Strobes held 3 clocks, then 1 idle clock
  task automatic io_write(logic [15:0] addr, logic [7:0] data);
    cpu.a      = addr;
    cpu.dout   = data;
    cpu.iorq_n = 1'b0;
    cpu.wr_n   = 1'b0;
    repeat (3) @(posedge sysclk);
    #DRIVE_DELAY;
    release_strobes();
    @(posedge sysclk);
    #DRIVE_DELAY;
  endtask

  // Samples on the falling edge of the last strobe clock
  task automatic io_read_check(logic [15:0] addr, logic [7:0] expected);
    cpu.a      = addr;
    cpu.iorq_n = 1'b0;
    cpu.rd_n   = 1'b0;
    repeat (2) @(posedge sysclk);
    @(negedge sysclk);
    assert (cpu_din == expected)
      else report_mismatch(test_name, expected, cpu_din);
    @(posedge sysclk);
    #DRIVE_DELAY;
    release_strobes();
    @(posedge sysclk);
    #DRIVE_DELAY;
  endtask

  // Read strobe low as well, so a selected register would claim the bus
  task automatic intack_cycle();
    cpu.a      = `ZXUNO_DATA_PORT;
    cpu.iorq_n = 1'b0;
    cpu.m1_n   = 1'b0;
    cpu.rd_n   = 1'b0;
    repeat (2) @(posedge sysclk);
    @(negedge sysclk);
    assert (cpu_din == 8'hFF)
      else report_mismatch(test_name, 8'hFF, cpu_din);
    @(posedge sysclk);
    #DRIVE_DELAY;
    release_strobes();
    @(posedge sysclk);
    #DRIVE_DELAY;
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    assert (actual == expected)
      else report_mismatch(name, {7'b0, expected}, {7'b0, actual});
  endtask

  // Flag order is bit 7 down to bit 0
  task automatic check_devopts_flags(logic [7:0] written);
    check_flag("devopts.disable_mixer", written[7], devopts.flags.disable_mixer);
    check_flag("devopts.disable_specdrum", written[6], devopts.flags.disable_specdrum);
    check_flag("devopts.disable_ulaplus", written[5], devopts.flags.disable_ulaplus);
    check_flag("devopts.disable_timexscr", written[4], devopts.flags.disable_timexscr);
    check_flag("devopts.disable_spisd", written[3], devopts.flags.disable_spisd);
    check_flag("devopts.disable_7ffd", written[2], devopts.flags.disable_7ffd);
    check_flag("devopts.disable_turboay", written[1], devopts.flags.disable_turboay);
    check_flag("devopts.disable_ay", written[0], devopts.flags.disable_ay);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    void'($urandom(RAND_SEED));
    id_text    = `COREID_TEXT;
    test_name  = "reset";
    rst_n      = 1'b0;
    cpu.a      = 16'h0000;
    cpu.dout   = 8'h00;
    release_strobes();
    repeat (RESET_CYCLES) @(posedge sysclk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    test_name = "addr_readback";
    for (int i = 0; i < 8; i++) begin
      value = 8'($urandom());
      io_write(`ZXUNO_ADDR_PORT, value);
      io_read_check(`ZXUNO_ADDR_PORT, value);
    end

    test_name = "scratch";
    io_write(`ZXUNO_ADDR_PORT, `REG_SCRATCH);
    for (int i = 0; i < 8; i++) begin
      value = 8'($urandom());
      io_write(`ZXUNO_DATA_PORT, value);
      io_read_check(`ZXUNO_DATA_PORT, value);
    end

    test_name = "devopts";
    io_write(`ZXUNO_ADDR_PORT, `REG_DEVOPTIONS);
    for (int i = 0; i < 6; i++) begin
      value = 8'($urandom());
      io_write(`ZXUNO_DATA_PORT, value);
      check_devopts_flags(value);
      io_read_check(`ZXUNO_DATA_PORT, value);
    end

    // String first, then zeros until the address is written again
    test_name = "coreid";
    io_write(`ZXUNO_ADDR_PORT, `REG_COREID);
    for (int i = 0; i < id_text.len(); i++) begin
      io_read_check(`ZXUNO_DATA_PORT, id_text[i]);
    end
    repeat (2) io_read_check(`ZXUNO_DATA_PORT, 8'h00);
    test_name = "coreid_restart";
    io_write(`ZXUNO_ADDR_PORT, `REG_COREID);
    io_read_check(`ZXUNO_DATA_PORT, id_text[0]);

    test_name = "intack";
    io_write(`ZXUNO_ADDR_PORT, `REG_SCRATCH);
    intack_cycle();
    io_write(`ZXUNO_ADDR_PORT, `REG_COREID);
    intack_cycle();
    io_write(`ZXUNO_ADDR_PORT, UNUSED_REG);
    intack_cycle();

    test_name = "unused_reg";
    io_read_check(`ZXUNO_DATA_PORT, 8'hFF);

    $display("Result: PASSED");
    $finish;
  end

  // Watchdog sized for the longest allowed run
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before all bus cycles completed");
    abort_run();
  end

endmodule

`default_nettype wire

// File: src/zxuno_io.sv
`timescale 1ns/100ps
`default_nettype none

`include "zxuno_config.svh"

module zxuno_io (
  input  wire                 sysclk,
  input  wire                 rst_n,
  input  zxuno_pkg::cpu_bus_t cpu,
  output logic [7:0]          cpu_din,
  output zxuno_pkg::devopts_t devopts
);

  zxuno_pkg::zxreg_bus_t zxreg;
  zxuno_pkg::rd_src_t    addr_rd;
  zxuno_pkg::rd_src_t    coreid_rd;
  zxuno_pkg::rd_src_t    scratch_rd;
  zxuno_pkg::rd_src_t    devopts_rd;
  logic                  intack;

  // ----------------------------------------
  // Register blocks
  // ----------------------------------------
  zxuno_regaddr zxuno_regaddr_inst (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .cpu     (cpu),
    .zxreg   (zxreg),
    .addr_rd (addr_rd)
  );

  coreid_reader coreid_reader_inst (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .cpu_rd_n  (cpu.rd_n),
    .zxreg     (zxreg),
    .coreid_rd (coreid_rd)
  );

  config_regs config_regs_inst (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .din        (cpu.dout),
    .zxreg      (zxreg),
    .scratch_rd (scratch_rd),
    .devopts_rd (devopts_rd),
    .devopts    (devopts)
  );

  // ----------------------------------------
  // CPU read data
  // ----------------------------------------
  // Interrupt acknowledge cycle
  assign intack = !cpu.iorq_n && !cpu.m1_n;

  // First match wins, intack above everything
  always_comb begin
    case (1'b1)
      intack        : cpu_din = `INTACK_DATA;
      addr_rd.oe    : cpu_din = addr_rd.dout;
      coreid_rd.oe  : cpu_din = coreid_rd.dout;
      scratch_rd.oe : cpu_din = scratch_rd.dout;
      devopts_rd.oe : cpu_din = devopts_rd.dout;
      default       : cpu_din = `IDLE_BUS_DATA;
    endcase
  end

endmodule

`default_nettype wire

// File: src/config_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "zxuno_config.svh"

module config_regs (
  input  wire                   sysclk,
  input  wire                   rst_n,
  input  wire [7:0]             din,
  input  zxuno_pkg::zxreg_bus_t zxreg,
  output zxuno_pkg::rd_src_t    scratch_rd,
  output zxuno_pkg::rd_src_t    devopts_rd,
  output zxuno_pkg::devopts_t   devopts
);

  logic                scratch_sel;
  logic                devopts_sel;
  logic [7:0]          scratch_q;
  zxuno_pkg::devopts_t devopts_q;

  assign scratch_sel = (zxreg.addr == `REG_SCRATCH);
  assign devopts_sel = (zxreg.addr == `REG_DEVOPTIONS);

  // ----------------------------------------
  // Scratch register
  // ----------------------------------------
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      scratch_q <= 8'h00;
    end else if (zxreg.regwr && scratch_sel) begin
      scratch_q <= din;
    end
  end

  assign scratch_rd.dout = scratch_q;
  assign scratch_rd.oe   = zxreg.regrd && scratch_sel;

  // ----------------------------------------
  // Device enable options
  // ----------------------------------------
  // Stored as the raw byte the CPU wrote
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      devopts_q.raw <= 8'h00;
    end else if (zxreg.regwr && devopts_sel) begin
      devopts_q.raw <= din;
    end
  end

  assign devopts_rd.dout = devopts_q.raw;
  assign devopts_rd.oe   = zxreg.regrd && devopts_sel;

  // Flags leave the block through the same word
  assign devopts = devopts_q;

  // Only one of the two registers answers a read
  assert property (@(posedge sysclk) disable iff (!rst_n)
    !(scratch_rd.oe && devopts_rd.oe))
    else $error("scratch and devopts both drive read data");

endmodule

`default_nettype wire

// File: src/coreid_reader.sv
`timescale 1ns/100ps
`default_nettype none

`include "zxuno_config.svh"

module coreid_reader (
  input  wire                   sysclk,
  input  wire                   rst_n,
  input  wire                   cpu_rd_n,
  input  zxuno_pkg::zxreg_bus_t zxreg,
  output zxuno_pkg::rd_src_t    coreid_rd
);

  localparam int IDX_W = $clog2(`COREID_LEN + 1);
  localparam logic [8*`COREID_LEN-1:0] ID_TEXT = `COREID_TEXT;

  logic             id_sel;
  logic             rd_n_q;
  logic             id_read_q;
  logic             advance;
  logic [IDX_W-1:0] idx;
  logic [7:0]       char_sel;

  assign id_sel = (zxreg.addr == `REG_COREID);

  // Step after the read strobe is released
  assign advance = cpu_rd_n && !rd_n_q && id_read_q;

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      rd_n_q    <= 1'b1;
      id_read_q <= 1'b0;
      idx       <= '0;
    end else begin
      rd_n_q    <= cpu_rd_n;
      id_read_q <= zxreg.regrd && id_sel;
      if (zxreg.regaddr_changed) begin
        idx <= '0;
      end else if (advance && (idx < IDX_W'(`COREID_LEN))) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // Past the end of the string the reader returns zero
  always_comb begin
    char_sel = 8'h00;
    for (int i = 0; i < `COREID_LEN; i++) begin
      if (idx == IDX_W'(i)) begin
        char_sel = ID_TEXT[8*(`COREID_LEN-1-i) +: 8];
      end
    end
  end

  assign coreid_rd.dout = char_sel;
  assign coreid_rd.oe   = zxreg.regrd && id_sel;

  assert property (@(posedge sysclk) disable iff (!rst_n)
    idx <= IDX_W'(`COREID_LEN))
    else $error("core id index out of range");

endmodule

`default_nettype wire

// File: src/zxuno_regaddr.sv
`timescale 1ns/100ps
`default_nettype none

`include "zxuno_config.svh"

module zxuno_regaddr (
  input  wire                   sysclk,
  input  wire                   rst_n,
  input  zxuno_pkg::cpu_bus_t   cpu,
  output zxuno_pkg::zxreg_bus_t zxreg,
  output zxuno_pkg::rd_src_t    addr_rd
);

  logic       io_cycle;
  logic       addr_port_hit;
  logic       data_port_hit;
  logic       addr_wr;
  logic       addr_wr_q;
  logic [7:0] addr_q;

  // ----------------------------------------
  // Port decode
  // ----------------------------------------
  // Interrupt acknowledge also lowers iorq_n, keep it out
  assign io_cycle      = !cpu.iorq_n && cpu.m1_n;
  assign addr_port_hit = io_cycle && (cpu.a == `ZXUNO_ADDR_PORT);
  assign data_port_hit = io_cycle && (cpu.a == `ZXUNO_DATA_PORT);

  assign addr_wr = addr_port_hit && !cpu.wr_n;

  // Address register, rewritten every clock of the strobe
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      addr_q    <= 8'h00;
      addr_wr_q <= 1'b0;
    end else begin
      addr_wr_q <= addr_wr;
      if (addr_wr) begin
        addr_q <= cpu.dout;
      end
    end
  end

  // ----------------------------------------
  // Register bus
  // ----------------------------------------
  assign zxreg.addr            = addr_q;
  assign zxreg.regrd           = data_port_hit && !cpu.rd_n;
  assign zxreg.regwr           = data_port_hit && !cpu.wr_n;
  // High only on the first clock of an address write
  assign zxreg.regaddr_changed = addr_wr && !addr_wr_q;

  // Address read back
  assign addr_rd.dout = addr_q;
  assign addr_rd.oe   = addr_port_hit && !cpu.rd_n;

  // Data port is never read and written in the same cycle
  assert property (@(posedge sysclk) disable iff (!rst_n)
    !(zxreg.regrd && zxreg.regwr))
    else $error("regrd and regwr both active");

endmodule

`default_nettype wire

// File: src/zxuno_pkg.sv
`default_nettype none

package zxuno_pkg;

  // ----------------------------------------
  // CPU side
  // ----------------------------------------
  // Z80 outputs as seen by the I/O subsystem
  typedef struct packed {
    logic [15:0] a;
    logic [7:0]  dout;
    logic        iorq_n;
    logic        m1_n;
    logic        rd_n;
    logic        wr_n;
  } cpu_bus_t;

  // Register bus shared by every register block
  typedef struct packed {
    logic [7:0] addr;
    logic       regrd;
    logic       regwr;
    logic       regaddr_changed;
  } zxreg_bus_t;

  // One read source for the CPU data mux
  typedef struct packed {
    logic [7:0] dout;
    logic       oe;
  } rd_src_t;

  // ----------------------------------------
  // Device options
  // ----------------------------------------
  typedef struct packed {
    logic disable_mixer;
    logic disable_specdrum;
    logic disable_ulaplus;
    logic disable_timexscr;
    logic disable_spisd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } devopts_flags_t;

  // CPU writes the raw byte, hardware looks at the flags
  typedef union packed {
    logic [7:0]     raw;
    devopts_flags_t flags;
  } devopts_t;

endpackage

`default_nettype wire

// File: src/zxuno_config.svh
`ifndef ZXUNO_CONFIG_SVH
`define ZXUNO_CONFIG_SVH

// ----------------------------------------
// I/O ports of the register interface
// ----------------------------------------
`define ZXUNO_ADDR_PORT 16'hFC3B
`define ZXUNO_DATA_PORT 16'hFD3B

// ----------------------------------------
// Register numbers
// ----------------------------------------
`define REG_COREID     8'hFF
`define REG_SCRATCH    8'hFE
`define REG_DEVOPTIONS 8'h0E

// Core identification string, first character sent first
`define COREID_TEXT "T01"
`define COREID_LEN  3

// Fixed values driven onto the CPU data bus
`define INTACK_DATA   8'hFF
`define IDLE_BUS_DATA 8'hFF

`endif
